//--- rtl/rvseed_pkg.sv
package rvseed_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_vector = 32'h8000_0000;

    localparam int mem_words = 256;
    localparam int mem_addr_bits = 8;

    // RV32 major opcodes seen by the predecoder
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_jal   = 7'b1101111;
    localparam logic [6:0] opc_jalr  = 7'b1100111;
    localparam logic [6:0] opc_op    = 7'b0110011;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    typedef enum logic [1:0] {
        class_seq,
        class_mem,
        class_jalr,
        class_muldiv
    } instr_class_e;

    typedef enum logic [1:0] {
        lsu_idle,
        lsu_wait_grant,
        lsu_wait_data
    } lsu_state_e;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_wait_grant,
        fetch_wait_data
    } fetch_state_e;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            gnt;
        logic            rvalid;
        logic [xlen-1:0] rdata;
    } mem_rsp_t;

    // Results of the execute stage, which lives outside this block
    typedef struct packed {
        logic            redirect;
        logic [xlen-1:0] redirect_pc;
        logic            muldiv_done;
        logic [xlen-1:0] mem_addr;
        logic            mem_we;
    } ex_ctrl_t;

    function automatic instr_class_e predecode(input logic [31:0] word);
        instr_class_e cls;
        cls = class_seq;
        case (word[6:0])
            opc_load, opc_store: cls = class_mem;
            opc_jal, opc_jalr:   cls = class_jalr;
            opc_op: begin
                if (word[31:25] == funct7_muldiv) begin
                    cls = class_muldiv;
                end
            end
            default: cls = class_seq;
        endcase
        return cls;
    endfunction

endpackage

//--- rtl/unified_sram.sv
`timescale 1ns/1ps

module unified_sram (
    input  logic                    clk,
    input  rvseed_pkg::mem_req_t    req,
    output logic [31:0]             rdata
);

    logic [31:0] mem [rvseed_pkg::mem_words];
    logic [rvseed_pkg::mem_addr_bits-1:0] idx;

    // Byte address to word index; upper address bits alias
    assign idx = req.addr[rvseed_pkg::mem_addr_bits+1:2];

    always_ff @(posedge clk) begin
        if (req.req) begin
            if (req.we) begin
                mem[idx] <= req.wdata;
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rvseed_pkg::mem_req_t    lsu_req,
    input  rvseed_pkg::mem_req_t    fetch_req,
    input  logic [31:0]             mem_rdata,
    output rvseed_pkg::mem_rsp_t    lsu_rsp,
    output rvseed_pkg::mem_rsp_t    fetch_rsp,
    output rvseed_pkg::mem_req_t    mem_req
);

    logic lsu_gnt;
    logic fetch_gnt;
    // Owner of the read that returns in the current cycle
    logic lsu_rd_pend;
    logic fetch_rd_pend;

    // Load/store side always wins
    assign lsu_gnt   = lsu_req.req;
    assign fetch_gnt = fetch_req.req && !lsu_req.req;

    // With no request at all fetch_req.req is low, so the memory idles
    assign mem_req = lsu_req.req ? lsu_req : fetch_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lsu_rd_pend   <= 1'b0;
            fetch_rd_pend <= 1'b0;
        end else begin
            lsu_rd_pend   <= lsu_gnt && !lsu_req.we;
            fetch_rd_pend <= fetch_gnt && !fetch_req.we;
        end
    end

    assign lsu_rsp.gnt    = lsu_gnt;
    assign lsu_rsp.rvalid = lsu_rd_pend;
    assign lsu_rsp.rdata  = mem_rdata;

    assign fetch_rsp.gnt    = fetch_gnt;
    assign fetch_rsp.rvalid = fetch_rd_pend;
    assign fetch_rsp.rdata  = mem_rdata;

endmodule

//--- rtl/fetch_port.sv
`timescale 1ns/1ps

module fetch_port (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ena,
    input  logic [rvseed_pkg::xlen-1:0]    pc,
    input  rvseed_pkg::mem_rsp_t           rsp,
    output rvseed_pkg::mem_req_t           req,
    output logic                           fetch_done,
    output rvseed_pkg::instr_class_e       instr_class,
    output logic [31:0]                    instr
);

    rvseed_pkg::fetch_state_e    state;
    logic [rvseed_pkg::xlen-1:0] last_pc;
    logic                        last_valid;
    logic                        new_pc;

    // A fetch is owed whenever the sequencer shows a PC not yet read
    assign new_pc = ena && (!last_valid || pc != last_pc);

    assign req.req   = (state == rvseed_pkg::fetch_wait_grant);
    assign req.we    = 1'b0;
    assign req.addr  = last_pc;
    assign req.wdata = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= rvseed_pkg::fetch_idle;
            last_pc    <= '0;
            last_valid <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                rvseed_pkg::fetch_idle: begin
                    if (new_pc) begin
                        last_pc    <= pc;
                        last_valid <= 1'b1;
                        state      <= rvseed_pkg::fetch_wait_grant;
                    end
                end
                rvseed_pkg::fetch_wait_grant: begin
                    if (rsp.gnt) begin
                        state <= rvseed_pkg::fetch_wait_data;
                    end
                end
                rvseed_pkg::fetch_wait_data: begin
                    if (rsp.rvalid) begin
                        fetch_done <= 1'b1;
                        state      <= rvseed_pkg::fetch_idle;
                    end
                end
                default: state <= rvseed_pkg::fetch_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rvseed_pkg::fetch_wait_data && rsp.rvalid) begin
            instr       <= rsp.rdata;
            instr_class <= rvseed_pkg::predecode(rsp.rdata);
        end
    end

endmodule

//--- rtl/lsu_port.sv
`timescale 1ns/1ps

module lsu_port (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_done,
    input  rvseed_pkg::instr_class_e    instr_class,
    input  logic [31:0]                 instr,
    input  rvseed_pkg::ex_ctrl_t        ex,
    input  rvseed_pkg::mem_rsp_t        rsp,
    output rvseed_pkg::mem_req_t        req,
    output logic                        lsu_done,
    output logic [31:0]                 load_data
);

    rvseed_pkg::lsu_state_e      state;
    logic [rvseed_pkg::xlen-1:0] acc_addr;
    logic                        acc_we;
    logic [31:0]                 acc_wdata;
    logic                        start;

    assign start = fetch_done && (instr_class == rvseed_pkg::class_mem);

    assign req.req   = (state == rvseed_pkg::lsu_wait_grant);
    assign req.we    = acc_we;
    assign req.addr  = acc_addr;
    assign req.wdata = acc_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= rvseed_pkg::lsu_idle;
            acc_we   <= 1'b0;
            lsu_done <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            case (state)
                rvseed_pkg::lsu_idle: begin
                    if (start) begin
                        acc_we <= ex.mem_we;
                        state  <= rvseed_pkg::lsu_wait_grant;
                    end
                end
                rvseed_pkg::lsu_wait_grant: begin
                    if (rsp.gnt) begin
                        if (acc_we) begin
                            // Store is done once the memory has taken it
                            lsu_done <= 1'b1;
                            state    <= rvseed_pkg::lsu_idle;
                        end else begin
                            state <= rvseed_pkg::lsu_wait_data;
                        end
                    end
                end
                rvseed_pkg::lsu_wait_data: begin
                    if (rsp.rvalid) begin
                        lsu_done <= 1'b1;
                        state    <= rvseed_pkg::lsu_idle;
                    end
                end
                default: state <= rvseed_pkg::lsu_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rvseed_pkg::lsu_idle && start) begin
            acc_addr  <= ex.mem_addr;
            acc_wdata <= instr;
        end
        if (state == rvseed_pkg::lsu_wait_data && rsp.rvalid) begin
            load_data <= rsp.rdata;
        end
    end

endmodule

//--- rtl/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           fetch_done,
    input  rvseed_pkg::instr_class_e       instr_class,
    input  logic                           lsu_done,
    input  rvseed_pkg::ex_ctrl_t           ex,
    output logic                           ena,
    output logic [rvseed_pkg::xlen-1:0]    pc
);

    // Class of the instruction whose completion is still outstanding
    logic                     pend_valid;
    rvseed_pkg::instr_class_e pend_class;
    // Jump seen at fetch_done, target not yet known
    logic                     jalr_wait;

    logic [rvseed_pkg::xlen-1:0] pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ena <= 1'b0;
        end else begin
            ena <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= rvseed_pkg::reset_vector;
            pend_valid <= 1'b0;
            pend_class <= rvseed_pkg::class_seq;
            jalr_wait  <= 1'b0;
        end else if (fetch_done) begin
            case (instr_class)
                rvseed_pkg::class_seq: begin
                    if (ex.redirect) begin
                        pc <= ex.redirect_pc;
                    end else begin
                        pc <= pc_plus4;
                    end
                end
                rvseed_pkg::class_jalr: begin
                    jalr_wait <= 1'b1;
                end
                default: begin
                    // Memory and mul/div wait for their own finish strobe
                    pend_valid <= 1'b1;
                    pend_class <= instr_class;
                end
            endcase
        end else if (jalr_wait) begin
            if (ex.redirect) begin
                pc        <= ex.redirect_pc;
                jalr_wait <= 1'b0;
            end
        end else if (pend_valid) begin
            if (pend_class == rvseed_pkg::class_mem && lsu_done) begin
                pc         <= pc_plus4;
                pend_valid <= 1'b0;
            end else if (pend_class == rvseed_pkg::class_muldiv && ex.muldiv_done) begin
                pc         <= pc_plus4;
                pend_valid <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/rvseed_fetch_top.sv
`timescale 1ns/1ps

module rvseed_fetch_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  rvseed_pkg::ex_ctrl_t           ex,
    output logic [rvseed_pkg::xlen-1:0]    pc,
    output logic                           fetch_done,
    output logic [31:0]                    instr,
    output rvseed_pkg::instr_class_e       instr_class,
    output logic                           lsu_done,
    output logic [31:0]                    load_data
);

    logic                 ena;
    rvseed_pkg::mem_req_t fetch_req;
    rvseed_pkg::mem_rsp_t fetch_rsp;
    rvseed_pkg::mem_req_t lsu_req;
    rvseed_pkg::mem_rsp_t lsu_rsp;
    rvseed_pkg::mem_req_t mem_req;
    logic [31:0]          mem_rdata;

    pc_sequencer u_pc_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_done  (fetch_done),
        .instr_class (instr_class),
        .lsu_done    (lsu_done),
        .ex          (ex),
        .ena         (ena),
        .pc          (pc)
    );

    fetch_port u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .ena         (ena),
        .pc          (pc),
        .rsp         (fetch_rsp),
        .req         (fetch_req),
        .fetch_done  (fetch_done),
        .instr_class (instr_class),
        .instr       (instr)
    );

    lsu_port u_lsu (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_done  (fetch_done),
        .instr_class (instr_class),
        .instr       (instr),
        .ex          (ex),
        .rsp         (lsu_rsp),
        .req         (lsu_req),
        .lsu_done    (lsu_done),
        .load_data   (load_data)
    );

    mem_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .lsu_req   (lsu_req),
        .fetch_req (fetch_req),
        .mem_rdata (mem_rdata),
        .lsu_rsp   (lsu_rsp),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req)
    );

    unified_sram u_sram (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

//--- verification/rvseed_fetch_assert.sv
`timescale 1ns/1ps

module rvseed_fetch_assert (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        ena,
    input rvseed_pkg::mem_req_t        fetch_req,
    input rvseed_pkg::mem_rsp_t        fetch_rsp,
    input rvseed_pkg::mem_req_t        lsu_req,
    input rvseed_pkg::mem_rsp_t        lsu_rsp,
    input logic                        fetch_done,
    input logic                        lsu_done,
    input logic [31:0]                 instr,
    input rvseed_pkg::instr_class_e    instr_class
);

    int unsigned err_count = 0;

    // Load or store outstanding from its fetch_done up to its lsu_done
    logic lsu_busy;

    // Class expected from the opcode and funct7 fields
    function automatic rvseed_pkg::instr_class_e class_of(input logic [31:0] w);
        if (w[6:0] == rvseed_pkg::opc_load || w[6:0] == rvseed_pkg::opc_store) begin
            return rvseed_pkg::class_mem;
        end
        if (w[6:0] == rvseed_pkg::opc_jal || w[6:0] == rvseed_pkg::opc_jalr) begin
            return rvseed_pkg::class_jalr;
        end
        if (w[6:0] == rvseed_pkg::opc_op && w[31:25] == rvseed_pkg::funct7_muldiv) begin
            return rvseed_pkg::class_muldiv;
        end
        return rvseed_pkg::class_seq;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lsu_busy <= 1'b0;
        end else if (fetch_done && instr_class == rvseed_pkg::class_mem) begin
            lsu_busy <= 1'b1;
        end else if (lsu_done) begin
            lsu_busy <= 1'b0;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !ena && !fetch_req.req && !lsu_req.req && !fetch_done && !lsu_done)
        else begin
            $error("Activity while reset is held");
            err_count++;
        end

    // No fetch may use the port while a load or store is outstanding
    fetch_gnt_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp.gnt |-> !lsu_busy)
        else begin
            $error("Fetch granted while a load/store access is outstanding");
            err_count++;
        end

    fetch_rvalid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp.gnt |=> fetch_rsp.rvalid && !lsu_rsp.rvalid)
        else begin
            $error("Fetch grant without rvalid one cycle later");
            err_count++;
        end

    lsu_rvalid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rsp.gnt && !lsu_req.we |=> lsu_rsp.rvalid && !fetch_rsp.rvalid)
        else begin
            $error("Load grant without rvalid one cycle later");
            err_count++;
        end

    fetch_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req.req && !fetch_rsp.gnt |=> fetch_req.req && $stable(fetch_req.addr)
            && $stable(fetch_req.we) && $stable(fetch_req.wdata))
        else begin
            $error("Fetch request dropped or changed before grant");
            err_count++;
        end

    // A load or store asks for the port right after its fetch_done
    lsu_req_follows: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_done && instr_class == rvseed_pkg::class_mem |=> lsu_req.req)
        else begin
            $error("No load/store request after a memory instruction");
            err_count++;
        end

    class_matches_word: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_done |-> instr_class == class_of(instr))
        else begin
            $error("Predecoded class does not match the fetched word");
            err_count++;
        end

endmodule

//--- verification/rvseed_fetch_tb.sv
`timescale 1ns/1ps

module rvseed_fetch_tb;

    localparam int num_instr   = 64;
    localparam int cycle_limit = 40 * num_instr + 100;

    logic                        clk;
    logic                        rst_n;
    rvseed_pkg::ex_ctrl_t        ex;
    logic [rvseed_pkg::xlen-1:0] pc;
    logic                        fetch_done;
    logic [31:0]                 instr;
    rvseed_pkg::instr_class_e    instr_class;
    logic                        lsu_done;
    logic [31:0]                 load_data;

    // Expected memory image and what each fetched word should do
    logic [31:0]              image [rvseed_pkg::mem_words];
    rvseed_pkg::instr_class_e img_class [rvseed_pkg::mem_words];
    logic                     mem_we_of [rvseed_pkg::mem_words];
    logic [7:0]               data_idx_of [rvseed_pkg::mem_words];

    logic [31:0] exp_pc;
    logic [15:0] lfsr_state;
    int          cycles = 0;

    rvseed_fetch_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex          (ex),
        .pc          (pc),
        .fetch_done  (fetch_done),
        .instr       (instr),
        .instr_class (instr_class),
        .lsu_done    (lsu_done),
        .load_data   (load_data)
    );

    bind rvseed_fetch_top rvseed_fetch_assert u_assert (
        .clk         (clk),
        .rst_n       (rst_n),
        .ena         (ena),
        .fetch_req   (fetch_req),
        .fetch_rsp   (fetch_rsp),
        .lsu_req     (lsu_req),
        .lsu_rsp     (lsu_rsp),
        .fetch_done  (fetch_done),
        .lsu_done    (lsu_done),
        .instr       (instr),
        .instr_class (instr_class)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the program did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    always @(negedge clk) begin
        if (uut.u_assert.err_count != 0) begin
            $display("A bound assertion on the memory bus or predecoder failed");
            $display("TESTS FAILED");
            $fatal(1, "Assertion failure");
        end
    end

    // 16-bit Galois LFSR, maximal length taps
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Jump target inside the program, never the current PC
    function automatic logic [31:0] pick_target(input logic [31:0] cur);
        logic [7:0]  r;
        logic [3:0]  slot;
        logic [31:0] t;
        r = rand_bits(4);
        slot = r[3:0];
        t = rvseed_pkg::reset_vector + {26'd0, slot, 2'b00};
        if (t == cur) begin
            slot = slot + 4'd1;
            t = rvseed_pkg::reset_vector + {26'd0, slot, 2'b00};
        end
        return t;
    endfunction

    task automatic report_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
        $display("TESTS FAILED");
        $fatal(1, "Value mismatch");
    endtask

    task automatic put_word(input int idx, input logic [31:0] word,
                            input rvseed_pkg::instr_class_e cls, input logic we,
                            input logic [7:0] didx);
        image[idx]       = word;
        img_class[idx]   = cls;
        mem_we_of[idx]   = we;
        data_idx_of[idx] = didx;
    endtask

    task automatic build_image();
        logic [7:0] i8;
        for (int i = 0; i < rvseed_pkg::mem_words; i++) begin
            i8 = i[7:0];
            // OP-IMM fill, so stray fetches are plain sequential words
            put_word(i, {~i8, i8, 9'd0, 7'b0010011}, rvseed_pkg::class_seq, 1'b0, 8'd0);
        end
        put_word(0,  32'h00100093, rvseed_pkg::class_seq,    1'b0, 8'd0);
        put_word(1,  32'h0020a023, rvseed_pkg::class_mem,    1'b1, 8'd200);
        put_word(2,  32'h0000a183, rvseed_pkg::class_mem,    1'b0, 8'd200);
        put_word(3,  32'h02208233, rvseed_pkg::class_muldiv, 1'b0, 8'd0);
        put_word(4,  32'h002081b3, rvseed_pkg::class_seq,    1'b0, 8'd0);
        put_word(5,  32'h0080006f, rvseed_pkg::class_jalr,   1'b0, 8'd0);
        put_word(6,  32'h123452b7, rvseed_pkg::class_seq,    1'b0, 8'd0);
        put_word(7,  32'h0050a223, rvseed_pkg::class_mem,    1'b1, 8'd201);
        put_word(8,  32'h0040a303, rvseed_pkg::class_mem,    1'b0, 8'd201);
        put_word(9,  32'h0220c3b3, rvseed_pkg::class_muldiv, 1'b0, 8'd0);
        put_word(10, 32'h000080e7, rvseed_pkg::class_jalr,   1'b0, 8'd0);
        put_word(11, 32'h00a00513, rvseed_pkg::class_seq,    1'b0, 8'd0);
        put_word(12, 32'h40208433, rvseed_pkg::class_seq,    1'b0, 8'd0);
        put_word(13, 32'h0080a423, rvseed_pkg::class_mem,    1'b1, 8'd202);
        put_word(14, 32'h0080a483, rvseed_pkg::class_mem,    1'b0, 8'd202);
        put_word(15, 32'h0220e533, rvseed_pkg::class_muldiv, 1'b0, 8'd0);
    endtask

    task automatic wait_fetch_done();
        do begin
            @(posedge clk);
            #1;
            assert (pc == exp_pc) else report_value("pc during fetch", pc, exp_pc);
        end while (!fetch_done);
    endtask

    task automatic hold_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #2;
            assert (pc == exp_pc) else report_value("pc while waiting", pc, exp_pc);
        end
    endtask

    task automatic run_instruction();
        logic [7:0]  idx;
        logic [7:0]  r;
        logic [7:0]  didx;
        logic [31:0] next_pc;
        idx = exp_pc[9:2];
        didx = data_idx_of[idx];
        next_pc = exp_pc + 32'd4;
        wait_fetch_done();
        assert (instr == image[idx]) else report_value("instruction word", instr, image[idx]);
        assert (instr_class == img_class[idx])
            else report_value("instruction class", {30'd0, instr_class}, {30'd0, img_class[idx]});
        #1;
        case (img_class[idx])
            rvseed_pkg::class_seq: begin
                r = rand_bits(2);
                if (r[1:0] == 2'b11) begin
                    next_pc = pick_target(exp_pc);
                    ex.redirect = 1'b1;
                    ex.redirect_pc = next_pc;
                end
                @(posedge clk);
                #2;
                ex.redirect = 1'b0;
            end
            rvseed_pkg::class_mem: begin
                ex.mem_addr = rvseed_pkg::reset_vector + {22'd0, didx, 2'b00};
                ex.mem_we = mem_we_of[idx];
                @(posedge clk);
                #2;
                ex.mem_addr = '0;
                ex.mem_we = 1'b0;
                while (!lsu_done) begin
                    assert (pc == exp_pc) else report_value("pc before lsu_done", pc, exp_pc);
                    @(posedge clk);
                    #2;
                end
                if (mem_we_of[idx]) begin
                    image[didx] = image[idx];
                end else begin
                    assert (load_data == image[didx])
                        else report_value("load data", load_data, image[didx]);
                end
                @(posedge clk);
                #2;
            end
            rvseed_pkg::class_muldiv: begin
                r = rand_bits(3);
                hold_cycles(1 + int'(r[2:0]));
                ex.muldiv_done = 1'b1;
                @(posedge clk);
                #2;
                ex.muldiv_done = 1'b0;
            end
            rvseed_pkg::class_jalr: begin
                r = rand_bits(3);
                hold_cycles(1 + int'(r[2:0]));
                next_pc = pick_target(exp_pc);
                ex.redirect = 1'b1;
                ex.redirect_pc = next_pc;
                @(posedge clk);
                #2;
                ex.redirect = 1'b0;
            end
        endcase
        assert (pc == next_pc) else report_value("pc after completion", pc, next_pc);
        exp_pc = next_pc;
    endtask

    initial begin
        rst_n = 1'b0;
        ex = '0;
        lfsr_state = 16'd99;
        build_image();
        for (int i = 0; i < rvseed_pkg::mem_words; i++) begin
            uut.u_sram.mem[i] = image[i];
        end
        exp_pc = rvseed_pkg::reset_vector;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int n = 0; n < num_instr; n++) begin
            run_instruction();
        end
        if (uut.u_assert.err_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "Bound assertion failures");
        end
    end

endmodule

//--- rvseed_fetch.f
rtl/rvseed_pkg.sv
rtl/unified_sram.sv
rtl/mem_arbiter.sv
rtl/fetch_port.sv
rtl/lsu_port.sv
rtl/pc_sequencer.sv
rtl/rvseed_fetch_top.sv
verification/rvseed_fetch_assert.sv
verification/rvseed_fetch_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rvseed_fetch_tb
FILELIST  = rvseed_fetch.f
OBJ_DIR   = obj_dir
LOG       = sim.log
# Let the testbench see every bound assertion failure before the run stops
SIM_ARGS  = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
